// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

    // address layout from the top is tag, index, word select and byte offset
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int SETS           = 64;
    localparam int NUM_WAYS       = 2;
    localparam int BYTES_PER_WORD = WORD_W / 8;

    localparam int OFFSET_W   = 2;
    localparam int WORD_SEL_W = 3;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = ADDR_W - INDEX_W - WORD_SEL_W - OFFSET_W;

    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [WORD_SEL_W-1:0]     word_sel_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_LOAD,
        OP_STORE,
        OP_REFILL
    } cache_op_t;

endpackage

// ==== hw/sdp_ram.sv ====
`timescale 1ns/1ps

module sdp_ram #(
    parameter type payload_t = logic
) (
    input  logic              clk,
    input  logic              we,
    input  dcache_pkg::index_t waddr,
    input  payload_t          wdata,
    input  dcache_pkg::index_t raddr,
    output payload_t          rdata
);
    import dcache_pkg::*;

    payload_t mem [SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // a colliding read returns the data being written
    always_ff @(posedge clk) begin
        if (we && (waddr == raddr)) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== hw/req_stage.sv ====
`timescale 1ns/1ps

module req_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_pkg::cache_op_t     op,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  dcache_pkg::word_t         store_data,
    input  dcache_pkg::byte_mask_t    byte_mask,
    input  dcache_pkg::line_t         refill_line,
    output dcache_pkg::cache_op_t     s_op,
    output dcache_pkg::tag_t          s_tag,
    output dcache_pkg::index_t        s_index,
    output dcache_pkg::word_sel_t     s_word_sel,
    output dcache_pkg::word_t         s_store_data,
    output dcache_pkg::byte_mask_t    s_byte_mask,
    output dcache_pkg::line_t         s_refill_line,
    output logic                      resp_valid
);
    import dcache_pkg::*;

    tag_t      addr_tag;
    index_t    addr_index;
    word_sel_t addr_word_sel;

    // field split of the incoming address
    assign addr_word_sel = addr[OFFSET_W +: WORD_SEL_W];
    assign addr_index    = addr[OFFSET_W + WORD_SEL_W +: INDEX_W];
    assign addr_tag      = addr[ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            s_op <= OP_IDLE;
        end else begin
            s_op <= op;
        end
    end

    // operands held for the compare cycle
    always_ff @(posedge clk) begin
        s_tag         <= addr_tag;
        s_index       <= addr_index;
        s_word_sel    <= addr_word_sel;
        s_store_data  <= store_data;
        s_byte_mask   <= byte_mask;
        s_refill_line <= refill_line;
    end

    assign resp_valid = (s_op != OP_IDLE);

endmodule

// ==== hw/cache_way.sv ====
`timescale 1ns/1ps

module cache_way (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::index_t     rd_index,
    input  dcache_pkg::tag_t       s_tag,
    input  dcache_pkg::index_t     s_index,
    input  dcache_pkg::word_sel_t  s_word_sel,
    input  dcache_pkg::word_t      s_store_data,
    input  dcache_pkg::byte_mask_t s_byte_mask,
    input  dcache_pkg::line_t      s_refill_line,
    input  logic                   fill_en,
    input  logic                   store_en,
    output logic                   way_hit,
    output dcache_pkg::line_t      way_line,
    output dcache_pkg::tag_t       way_tag,
    output logic                   way_dirty
);
    import dcache_pkg::*;

    logic [SETS-1:0]           valid_q;
    logic                      set_valid;
    logic                      dirty_rdata;
    logic                      dirty_we;
    word_t                     cur_word;
    word_t                     merged_word;
    logic [WORDS_PER_LINE-1:0] word_we;
    line_t                     word_wdata;

    // valid bits live in flops so reset can clear them
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[s_index] <= 1'b1;
        end
    end

    assign set_valid = valid_q[s_index];
    assign way_hit   = set_valid && (way_tag == s_tag);
    assign way_dirty = dirty_rdata && set_valid;

    // store merge on the word addressed by the request
    assign cur_word = way_line[s_word_sel];

    always_comb begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (s_byte_mask[b]) begin
                merged_word[b*8 +: 8] = s_store_data[b*8 +: 8];
            end else begin
                merged_word[b*8 +: 8] = cur_word[b*8 +: 8];
            end
        end
    end

    for (genvar k = 0; k < WORDS_PER_LINE; k++) begin : g_word
        assign word_we[k] = fill_en || (store_en && (s_word_sel == WORD_SEL_W'(k)));
        assign word_wdata[k] = fill_en ? s_refill_line[k] : merged_word;

        sdp_ram #(
            .payload_t(word_t)
        ) i_data_ram (
            .clk  (clk),
            .we   (word_we[k]),
            .waddr(s_index),
            .wdata(word_wdata[k]),
            .raddr(rd_index),
            .rdata(way_line[k])
        );
    end

    sdp_ram #(
        .payload_t(tag_t)
    ) i_tag_ram (
        .clk  (clk),
        .we   (fill_en),
        .waddr(s_index),
        .wdata(s_tag),
        .raddr(rd_index),
        .rdata(way_tag)
    );

    // refill leaves the line clean, a store marks it dirty
    assign dirty_we = fill_en || store_en;

    sdp_ram #(
        .payload_t(logic)
    ) i_dirty_ram (
        .clk  (clk),
        .we   (dirty_we),
        .waddr(s_index),
        .wdata(store_en),
        .raddr(rd_index),
        .rdata(dirty_rdata)
    );

endmodule

// ==== hw/way_select.sv ====
`timescale 1ns/1ps

module way_select (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::cache_op_t s_op,
    input  dcache_pkg::index_t    s_index,
    input  dcache_pkg::word_sel_t s_word_sel,
    input  logic                  hit0,
    input  logic                  hit1,
    input  dcache_pkg::line_t     line0,
    input  dcache_pkg::line_t     line1,
    input  dcache_pkg::tag_t      tag0,
    input  dcache_pkg::tag_t      tag1,
    input  logic                  dirty0,
    input  logic                  dirty1,
    output logic                  hit,
    output dcache_pkg::word_t     load_data,
    output logic                  victim_dirty,
    output dcache_pkg::tag_t      victim_tag,
    output dcache_pkg::line_t     victim_line,
    output logic                  fill_en0,
    output logic                  fill_en1,
    output logic                  store_en0,
    output logic                  store_en1
);
    import dcache_pkg::*;

    logic [SETS-1:0]     lru_q;
    logic                victim_way;
    logic                hit_way;
    logic [NUM_WAYS-1:0] fill_en;
    logic [NUM_WAYS-1:0] store_en;

    // lru bit names the way used last, so the victim is the other one
    assign victim_way = ~lru_q[s_index];
    assign hit        = hit0 || hit1;
    assign hit_way    = ~hit0;

    always_comb begin
        if (hit0) begin
            load_data = line0[s_word_sel];
        end else if (hit1) begin
            load_data = line1[s_word_sel];
        end else begin
            load_data = '0;
        end
    end

    assign victim_tag   = victim_way ? tag1 : tag0;
    assign victim_line  = victim_way ? line1 : line0;
    assign victim_dirty = victim_way ? dirty1 : dirty0;

    // way 0 wins a double hit so at most one strobe rises
    assign fill_en[0]  = (s_op == OP_REFILL) && !victim_way;
    assign fill_en[1]  = (s_op == OP_REFILL) && victim_way;
    assign store_en[0] = (s_op == OP_STORE) && hit0;
    assign store_en[1] = (s_op == OP_STORE) && hit1 && !hit0;

    assign fill_en0  = fill_en[0];
    assign fill_en1  = fill_en[1];
    assign store_en0 = store_en[0];
    assign store_en1 = store_en[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else begin
            case (s_op)
                OP_LOAD, OP_STORE: begin
                    if (hit) begin
                        lru_q[s_index] <= hit_way;
                    end
                end
                OP_REFILL: lru_q[s_index] <= victim_way;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  dcache_pkg::cache_op_t         op,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  dcache_pkg::word_t             store_data,
    input  dcache_pkg::byte_mask_t        byte_mask,
    input  dcache_pkg::line_t             refill_line,
    output logic                          resp_valid,
    output logic                          hit,
    output dcache_pkg::word_t             load_data,
    output logic                          victim_dirty,
    output dcache_pkg::tag_t              victim_tag,
    output dcache_pkg::line_t             victim_line
);
    import dcache_pkg::*;

    index_t     rd_index;
    cache_op_t  s_op;
    tag_t       s_tag;
    index_t     s_index;
    word_sel_t  s_word_sel;
    word_t      s_store_data;
    byte_mask_t s_byte_mask;
    line_t      s_refill_line;

    logic  hit0;
    logic  hit1;
    line_t line0;
    line_t line1;
    tag_t  tag0;
    tag_t  tag1;
    logic  dirty0;
    logic  dirty1;
    logic  fill_en0;
    logic  fill_en1;
    logic  store_en0;
    logic  store_en1;

    // rams are read with the live index so data is ready a cycle later
    assign rd_index = addr[OFFSET_W + WORD_SEL_W +: INDEX_W];

    req_stage i_req_stage (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .addr         (addr),
        .store_data   (store_data),
        .byte_mask    (byte_mask),
        .refill_line  (refill_line),
        .s_op         (s_op),
        .s_tag        (s_tag),
        .s_index      (s_index),
        .s_word_sel   (s_word_sel),
        .s_store_data (s_store_data),
        .s_byte_mask  (s_byte_mask),
        .s_refill_line(s_refill_line),
        .resp_valid   (resp_valid)
    );

    cache_way i_way0 (
        .clk          (clk),
        .rst          (rst),
        .rd_index     (rd_index),
        .s_tag        (s_tag),
        .s_index      (s_index),
        .s_word_sel   (s_word_sel),
        .s_store_data (s_store_data),
        .s_byte_mask  (s_byte_mask),
        .s_refill_line(s_refill_line),
        .fill_en      (fill_en0),
        .store_en     (store_en0),
        .way_hit      (hit0),
        .way_line     (line0),
        .way_tag      (tag0),
        .way_dirty    (dirty0)
    );

    cache_way i_way1 (
        .clk          (clk),
        .rst          (rst),
        .rd_index     (rd_index),
        .s_tag        (s_tag),
        .s_index      (s_index),
        .s_word_sel   (s_word_sel),
        .s_store_data (s_store_data),
        .s_byte_mask  (s_byte_mask),
        .s_refill_line(s_refill_line),
        .fill_en      (fill_en1),
        .store_en     (store_en1),
        .way_hit      (hit1),
        .way_line     (line1),
        .way_tag      (tag1),
        .way_dirty    (dirty1)
    );

    way_select i_way_select (
        .clk         (clk),
        .rst         (rst),
        .s_op        (s_op),
        .s_index     (s_index),
        .s_word_sel  (s_word_sel),
        .hit0        (hit0),
        .hit1        (hit1),
        .line0       (line0),
        .line1       (line1),
        .tag0        (tag0),
        .tag1        (tag1),
        .dirty0      (dirty0),
        .dirty1      (dirty1),
        .hit         (hit),
        .load_data   (load_data),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .victim_line (victim_line),
        .fill_en0    (fill_en0),
        .fill_en1    (fill_en1),
        .store_en0   (store_en0),
        .store_en1   (store_en1)
    );

endmodule

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    typedef struct {
        cache_op_t         op;
        logic [ADDR_W-1:0] addr;
        word_t             data;
        byte_mask_t        mask;
        logic              exp_hit;
        logic              exp_vdirty;
    } op_entry_t;

    localparam tag_t TAG_A = 21'h1a2b3;
    localparam tag_t TAG_B = 21'h0c0de;
    localparam tag_t TAG_C = 21'h15555;

    logic              clk;
    logic              rst;
    cache_op_t         op;
    logic [ADDR_W-1:0] addr;
    word_t             store_data;
    byte_mask_t        byte_mask;
    line_t             refill_line;
    logic              resp_valid;
    logic              hit;
    word_t             load_data;
    logic              victim_dirty;
    tag_t              victim_tag;
    line_t             victim_line;

    op_entry_t   op_table[$];
    int          cycle_count;
    int          cycle_limit;
    int          error_count;
    logic [31:0] lcg_state;

    // reference model per way and set
    tag_t  m_tag   [NUM_WAYS][SETS];
    logic  m_valid [NUM_WAYS][SETS];
    logic  m_dirty [NUM_WAYS][SETS];
    line_t m_line  [NUM_WAYS][SETS];
    logic  m_lru   [SETS];

    // what the op in its compare cycle should show
    int        exp_entry;
    cache_op_t exp_op;
    logic      exp_hit;
    logic      exp_vdirty;
    word_t     exp_load;
    logic      exp_vvalid;
    tag_t      exp_vtag;
    line_t     exp_vline;

    dcache_top i_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .addr        (addr),
        .store_data  (store_data),
        .byte_mask   (byte_mask),
        .refill_line (refill_line),
        .resp_valid  (resp_valid),
        .hit         (hit),
        .load_data   (load_data),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .victim_line (victim_line)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] expected,
                                   input logic [255:0] got);
        error_count++;
        $display("Fail: entry %0d %s expected %0h got %0h", exp_entry, name, expected, got);
        stop_run();
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    task automatic add_entry(input cache_op_t o, input tag_t t, input int idx, input int w,
                             input word_t d, input byte_mask_t m, input logic eh,
                             input logic evd);
        op_entry_t e;
        e.op         = o;
        e.addr       = {t, index_t'(idx), word_sel_t'(w), 2'b00};
        e.data       = d;
        e.mask       = m;
        e.exp_hit    = eh;
        e.exp_vdirty = evd;
        op_table.push_back(e);
    endtask

    task automatic build_table();
        // cold misses after reset
        add_entry(OP_LOAD, TAG_A, 5, 0, '0, '0, 0, 0);
        add_entry(OP_LOAD, TAG_B, 9, 3, '0, '0, 0, 0);
        add_entry(OP_IDLE, '0, 0, 0, '0, '0, 0, 0);
        add_entry(OP_LOAD, TAG_C, 63, 7, '0, '0, 0, 0);
        // refill into way 1, then read the whole line back to back
        add_entry(OP_REFILL, TAG_A, 5, 0, '0, '0, 0, 0);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            add_entry(OP_LOAD, TAG_A, 5, w, '0, '0, 1, 0);
        end
        add_entry(OP_REFILL, TAG_B, 5, 0, '0, '0, 0, 0);
        add_entry(OP_LOAD, TAG_B, 5, 2, '0, '0, 1, 0);
        add_entry(OP_LOAD, TAG_A, 5, 6, '0, '0, 1, 0);
        // partial stores and stores that miss
        add_entry(OP_STORE, TAG_A, 5, 1, 32'hdeadbeef, 4'b0101, 1, 0);
        add_entry(OP_LOAD, TAG_A, 5, 1, '0, '0, 1, 0);
        add_entry(OP_STORE, TAG_A, 5, 4, 32'h12345678, 4'b1000, 1, 0);
        add_entry(OP_STORE, TAG_B, 5, 2, 32'hcafef00d, 4'b0011, 1, 0);
        add_entry(OP_LOAD, TAG_B, 5, 2, '0, '0, 1, 1);
        add_entry(OP_STORE, TAG_C, 5, 0, 32'hffffffff, 4'b1111, 0, 1);
        add_entry(OP_LOAD, TAG_A, 5, 0, '0, '0, 1, 1);
        add_entry(OP_STORE, TAG_C, 9, 0, 32'h55aa55aa, 4'b1111, 0, 0);
        add_entry(OP_LOAD, TAG_A, 5, 4, '0, '0, 1, 1);
        // evictions steered by lru
        add_entry(OP_LOAD, TAG_B, 5, 0, '0, '0, 1, 1);
        add_entry(OP_REFILL, TAG_C, 5, 0, '0, '0, 0, 1);
        add_entry(OP_LOAD, TAG_C, 5, 5, '0, '0, 1, 1);
        add_entry(OP_LOAD, TAG_A, 5, 0, '0, '0, 0, 1);
        add_entry(OP_REFILL, TAG_A, 5, 0, '0, '0, 0, 1);
        add_entry(OP_REFILL, TAG_B, 5, 0, '0, '0, 0, 0);
        add_entry(OP_LOAD, TAG_B, 5, 3, '0, '0, 1, 0);
        add_entry(OP_LOAD, TAG_A, 5, 3, '0, '0, 1, 0);
        // store followed at once by a load in a second set
        add_entry(OP_REFILL, TAG_C, 33, 0, '0, '0, 0, 0);
        add_entry(OP_LOAD, TAG_C, 33, 7, '0, '0, 1, 0);
        add_entry(OP_STORE, TAG_C, 33, 7, 32'h0badf00d, 4'b1111, 1, 0);
        add_entry(OP_LOAD, TAG_C, 33, 7, '0, '0, 1, 0);
        add_entry(OP_REFILL, TAG_B, 33, 0, '0, '0, 0, 0);
        add_entry(OP_LOAD, TAG_C, 33, 7, '0, '0, 1, 1);
        add_entry(OP_LOAD, TAG_B, 33, 1, '0, '0, 1, 0);
        add_entry(OP_IDLE, '0, 0, 0, '0, '0, 0, 0);
        add_entry(OP_LOAD, TAG_A, 9, 0, '0, '0, 0, 0);
    endtask

    task automatic drive_entry(input op_entry_t e);
        op         = e.op;
        addr       = e.addr;
        store_data = e.data;
        byte_mask  = e.mask;
        if (e.op == OP_REFILL) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                lcg_state      = lcg_next(lcg_state);
                refill_line[k] = lcg_state;
            end
        end
    endtask

    task automatic predict_and_update(input op_entry_t e, input int n);
        tag_t      t;
        index_t    idx;
        word_sel_t w;
        logic      h0;
        logic      h1;
        logic      vw;
        logic      hw;
        logic      model_vdirty;

        t   = e.addr[ADDR_W-1 -: TAG_W];
        idx = e.addr[OFFSET_W + WORD_SEL_W +: INDEX_W];
        w   = e.addr[OFFSET_W +: WORD_SEL_W];
        h0  = m_valid[0][idx] && (m_tag[0][idx] == t);
        h1  = m_valid[1][idx] && (m_tag[1][idx] == t);
        vw  = ~m_lru[idx];
        hw  = ~h0;
        model_vdirty = m_dirty[vw][idx] && m_valid[vw][idx];

        exp_entry  = n;
        exp_op     = e.op;
        exp_hit    = e.exp_hit;
        exp_vdirty = e.exp_vdirty;
        exp_load   = h0 ? m_line[0][idx][w] : (h1 ? m_line[1][idx][w] : '0);
        exp_vvalid = m_valid[vw][idx];
        exp_vtag   = m_tag[vw][idx];
        exp_vline  = m_line[vw][idx];
        if (e.op == OP_IDLE) begin
            return;
        end

        assert (((h0 || h1) == e.exp_hit) && (model_vdirty == e.exp_vdirty)) else begin
            error_count++;
            $display("reference model and stimulus table disagree at entry %0d", n);
            stop_run();
        end

        if ((e.op == OP_LOAD) && (h0 || h1)) begin
            m_lru[idx] = hw;
        end else if ((e.op == OP_STORE) && (h0 || h1)) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (e.mask[b]) begin
                    m_line[hw][idx][w][b*8 +: 8] = e.data[b*8 +: 8];
                end
            end
            m_dirty[hw][idx] = 1'b1;
            m_lru[idx]       = hw;
        end else if (e.op == OP_REFILL) begin
            m_line[vw][idx]  = refill_line;
            m_tag[vw][idx]   = t;
            m_valid[vw][idx] = 1'b1;
            m_dirty[vw][idx] = 1'b0;
            m_lru[idx]       = vw;
        end
    endtask

    task automatic check_pending();
        assert (resp_valid === (exp_op != OP_IDLE))
            else report_mismatch("resp_valid", exp_op != OP_IDLE, resp_valid);
        if (exp_op != OP_IDLE) begin
            assert (hit === exp_hit) else report_mismatch("hit", exp_hit, hit);
            assert (victim_dirty === exp_vdirty)
                else report_mismatch("victim_dirty", exp_vdirty, victim_dirty);
            assert (load_data === exp_load)
                else report_mismatch("load_data", exp_load, load_data);
            // victim contents only mean something once the way was filled
            if (exp_vvalid) begin
                assert (victim_tag === exp_vtag)
                    else report_mismatch("victim_tag", exp_vtag, victim_tag);
                assert (victim_line === exp_vline)
                    else report_mismatch("victim_line", exp_vline, victim_line);
            end
        end
    endtask

    initial begin
        op_entry_t idle_entry;

        rst         = 1'b1;
        op          = OP_IDLE;
        addr        = '0;
        store_data  = '0;
        byte_mask   = '0;
        refill_line = '0;
        cycle_count = 0;
        cycle_limit = 1000;
        error_count = 0;
        lcg_state   = 32'hd3a6a660;
        for (int s = 0; s < SETS; s++) begin
            for (int v = 0; v < NUM_WAYS; v++) begin
                m_tag[v][s]   = '0;
                m_valid[v][s] = 1'b0;
                m_dirty[v][s] = 1'b0;
                m_line[v][s]  = '0;
            end
            m_lru[s] = 1'b0;
        end
        build_table();
        cycle_limit = op_table.size() + 20;

        idle_entry = '{OP_IDLE, '0, '0, '0, 1'b0, 1'b0};
        predict_and_update(idle_entry, -1);

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < op_table.size(); i++) begin
            @(posedge clk);
            #2;
            drive_entry(op_table[i]);
            @(negedge clk);
            check_pending();
            predict_and_update(op_table[i], i);
        end

        // drain the last op, then expect no pulse
        @(posedge clk);
        #2;
        drive_entry(idle_entry);
        @(negedge clk);
        check_pending();
        predict_and_update(idle_entry, op_table.size());
        @(negedge clk);
        check_pending();

        if (error_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

// ==== src.f ====
hw/dcache_pkg.sv
hw/sdp_ram.sv
hw/req_stage.sv
hw/cache_way.sv
hw/way_select.sv
hw/dcache_top.sv
bench/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hw/dcache_pkg.sv
  - hw/sdp_ram.sv
  - hw/req_stage.sv
  - hw/cache_way.sv
  - hw/way_select.sv
  - hw/dcache_top.sv
  - target: test
    files:
      - bench/tb_dcache.sv
